// File: hw/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath and memory sizes
`define CPU_WORD_W      16
`define CPU_ADDR_W      8
`define CPU_MEM_DEPTH   256
`define CPU_REG_COUNT   8
`define CPU_REG_IDX_W   3
`define CPU_OP_W        5

// opcodes, instruction bits 15..11
`define CPU_OP_NOP      5'b00000
`define CPU_OP_HALT     5'b00001
`define CPU_OP_LOAD     5'b00010
`define CPU_OP_STORE    5'b00011
`define CPU_OP_LDIH     5'b10000
`define CPU_OP_ADD      5'b01000
`define CPU_OP_ADDI     5'b01001
`define CPU_OP_SUB      5'b01011
`define CPU_OP_SUBI     5'b10011
`define CPU_OP_CMP      5'b01100
`define CPU_OP_AND      5'b01101
`define CPU_OP_OR       5'b01111
`define CPU_OP_XOR      5'b01110

// control transfers, all start with 2'b11
`define CPU_OP_JUMP     5'b11000
`define CPU_OP_BZ       5'b11010
`define CPU_OP_BNZ      5'b11011
`define CPU_OP_BN       5'b11100
`define CPU_OP_BNN      5'b11101

`endif

// File: hw/cpu_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [`CPU_ADDR_W-1:0] addr_t;
	typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;
	typedef logic [`CPU_OP_W-1:0] opcode_t;

	typedef enum logic {idle, exec} run_state_e;

	// all-zero word decodes as NOP
	localparam word_t nop_instr = '0;

	// space 0 is program memory, 1 is data memory
	typedef struct packed {
		logic  we;
		logic  space;
		addr_t addr;
		word_t wdata;
	} host_req_t;

	typedef struct packed {
		word_t instr;
		word_t operand_a;
		word_t operand_b;
		word_t store_data;
	} exec_req_t;

	typedef struct packed {
		word_t instr;
		word_t result;
		word_t store_data;
		logic  we;
	} mem_req_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t index;
		word_t    value;
	} reg_write_t;

	//////////////////////////////////////////////////
	// instruction field decode

	function automatic opcode_t op_of(word_t instr);
		return instr[15:11];
	endfunction

	function automatic reg_idx_t r1_of(word_t instr);
		return instr[10:8];
	endfunction

	function automatic reg_idx_t r2_of(word_t instr);
		return instr[6:4];
	endfunction

	function automatic reg_idx_t r3_of(word_t instr);
		return instr[2:0];
	endfunction

	function automatic logic is_control(opcode_t op);
		return op[4:3] == 2'b11;
	endfunction

	// r1 <= r2 op r3
	function automatic logic is_reg3(opcode_t op);
		return op inside {`CPU_OP_ADD, `CPU_OP_SUB, `CPU_OP_CMP,
			`CPU_OP_AND, `CPU_OP_OR, `CPU_OP_XOR};
	endfunction

	function automatic logic reads_r1(opcode_t op);
		return op inside {`CPU_OP_STORE, `CPU_OP_ADDI, `CPU_OP_SUBI, `CPU_OP_LDIH,
			`CPU_OP_BZ, `CPU_OP_BNZ, `CPU_OP_BN, `CPU_OP_BNN};
	endfunction

	function automatic logic reads_r2(opcode_t op);
		return is_reg3(op) || op == `CPU_OP_LOAD || op == `CPU_OP_STORE;
	endfunction

	// opcodes that leave a value in r1
	function automatic logic writes_reg(opcode_t op);
		return op inside {`CPU_OP_LOAD, `CPU_OP_LDIH, `CPU_OP_ADD, `CPU_OP_ADDI,
			`CPU_OP_SUB, `CPU_OP_SUBI, `CPU_OP_AND, `CPU_OP_OR, `CPU_OP_XOR};
	endfunction

endpackage

`default_nettype wire

// File: hw/run_control.sv
`timescale 1ns/1ns
`default_nettype none

module run_control (
	input  wire  clock,
	input  wire  reset,
	input  wire  i_start,
	input  wire  i_enable,
	input  wire  i_wb_halt,
	output logic o_running,
	output logic o_advance,
	output logic o_clear
);

	cpu_pkg::run_state_e state;
	cpu_pkg::run_state_e state_next;

	always_comb
	begin
		state_next = state;
		case (state)
			cpu_pkg::idle:
				if (i_start && i_enable)
					state_next = cpu_pkg::exec;
			cpu_pkg::exec:
				if (i_enable && i_wb_halt)
					state_next = cpu_pkg::idle;
			default:
				state_next = cpu_pkg::idle;
		endcase
	end

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			state <= cpu_pkg::idle;
		else
			state <= state_next;
	end

	assign o_running = (state == cpu_pkg::exec);
	// HALT in writeback freezes the pipe for the last exec cycle
	assign o_advance = o_running && i_enable && !i_wb_halt;
	assign o_clear = (state == cpu_pkg::idle) && i_start && i_enable;

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module fetch_stage (
	input  wire                       clock,
	input  wire                       reset,
	input  wire                       i_advance,
	input  wire                       i_clear,
	input  wire cpu_pkg::host_req_t   i_host,
	input  wire cpu_pkg::word_t       i_operand_instr,
	input  wire cpu_pkg::word_t       i_execute_instr,
	input  wire cpu_pkg::mem_req_t    i_mem,
	input  wire                       i_flag_z,
	input  wire                       i_flag_n,
	output cpu_pkg::word_t            o_instr
);

	cpu_pkg::word_t prog_mem [`CPU_MEM_DEPTH];
	cpu_pkg::addr_t pc;
	cpu_pkg::word_t fetched;
	cpu_pkg::opcode_t mem_op;
	logic load_use;
	logic control_busy;
	logic taken;

	// true when consumer reads the register a LOAD producer writes
	function automatic logic load_hazard(cpu_pkg::word_t producer, cpu_pkg::word_t consumer);
		cpu_pkg::opcode_t c_op;
		cpu_pkg::reg_idx_t dest;
		c_op = cpu_pkg::op_of(consumer);
		dest = cpu_pkg::r1_of(producer);
		return cpu_pkg::op_of(producer) == `CPU_OP_LOAD
			&& ((cpu_pkg::reads_r1(c_op) && cpu_pkg::r1_of(consumer) == dest)
			|| (cpu_pkg::reads_r2(c_op) && cpu_pkg::r2_of(consumer) == dest)
			|| (cpu_pkg::is_reg3(c_op) && cpu_pkg::r3_of(consumer) == dest));
	endfunction

	//////////////////////////////////////////////////
	// program memory

	always_ff @(posedge clock)
	begin
		if (i_host.we && !i_host.space)
			prog_mem[i_host.addr] <= i_host.wdata;
	end

	assign fetched = prog_mem[pc];

	//////////////////////////////////////////////////
	// stall and redirect

	// o_instr sits in operand, i_operand_instr in execute
	assign load_use = load_hazard(o_instr, fetched) || load_hazard(i_operand_instr, fetched);
	assign control_busy = cpu_pkg::is_control(cpu_pkg::op_of(o_instr))
		|| cpu_pkg::is_control(cpu_pkg::op_of(i_operand_instr));

	// branch resolves in the memory stage with flags of the older instructions
	assign mem_op = cpu_pkg::op_of(i_execute_instr);

	always_comb
	begin
		case (mem_op)
			`CPU_OP_JUMP: taken = 1'b1;
			`CPU_OP_BZ:   taken = i_flag_z;
			`CPU_OP_BNZ:  taken = !i_flag_z;
			`CPU_OP_BN:   taken = i_flag_n;
			`CPU_OP_BNN:  taken = !i_flag_n;
			default:      taken = 1'b0;
		endcase
	end

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			pc <= '0;
			o_instr <= cpu_pkg::nop_instr;
		end
		else if (i_clear)
		begin
			pc <= '0;
			o_instr <= cpu_pkg::nop_instr;
		end
		else if (i_advance)
		begin
			if (load_use || control_busy)
				o_instr <= cpu_pkg::nop_instr;
			else if (taken)
			begin
				pc <= i_mem.result[`CPU_ADDR_W-1:0];
				o_instr <= cpu_pkg::nop_instr;
			end
			else
			begin
				pc <= pc + 1'b1;
				o_instr <= fetched;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/operand_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module operand_stage (
	input  wire                       clock,
	input  wire                       reset,
	input  wire                       i_advance,
	input  wire                       i_clear,
	input  wire cpu_pkg::word_t       i_instr,
	input  wire cpu_pkg::word_t       i_execute_result,
	input  wire cpu_pkg::word_t       i_mem_result,
	input  wire cpu_pkg::mem_req_t    i_mem,
	input  wire cpu_pkg::reg_write_t  i_write,
	output cpu_pkg::exec_req_t        o_exec,
	output cpu_pkg::word_t            o_instr
);

	cpu_pkg::word_t regs [`CPU_REG_COUNT];
	cpu_pkg::opcode_t op;
	cpu_pkg::word_t r1_val;
	cpu_pkg::word_t r2_val;
	cpu_pkg::word_t r3_val;
	cpu_pkg::word_t imm;
	cpu_pkg::exec_req_t exec_next;

	// youngest writer first: execute, memory, writeback, then the file
	function automatic cpu_pkg::word_t read_reg(cpu_pkg::reg_idx_t idx);
		cpu_pkg::word_t value;
		if (cpu_pkg::writes_reg(cpu_pkg::op_of(o_exec.instr))
			&& cpu_pkg::r1_of(o_exec.instr) == idx)
			value = i_execute_result;
		else if (cpu_pkg::writes_reg(cpu_pkg::op_of(i_mem.instr))
			&& cpu_pkg::r1_of(i_mem.instr) == idx)
			value = i_mem_result;
		else if (i_write.valid && i_write.index == idx)
			value = i_write.value;
		else
			value = regs[idx];
		return value;
	endfunction

	//////////////////////////////////////////////////
	// register file

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (i_advance && i_write.valid)
			regs[i_write.index] <= i_write.value;
	end

	//////////////////////////////////////////////////
	// operand selection

	always_comb
	begin
		op = cpu_pkg::op_of(i_instr);
		r1_val = read_reg(cpu_pkg::r1_of(i_instr));
		r2_val = read_reg(cpu_pkg::r2_of(i_instr));
		r3_val = read_reg(cpu_pkg::r3_of(i_instr));

		case (op)
			`CPU_OP_LDIH:                 imm = {i_instr[7:0], 8'b0};
			`CPU_OP_LOAD, `CPU_OP_STORE:  imm = {12'b0, i_instr[3:0]};
			default:                      imm = {8'b0, i_instr[7:0]};
		endcase

		exec_next.instr = i_instr;
		// immediate forms and branches take r1 as the base
		exec_next.operand_a = cpu_pkg::reads_r2(op) ? r2_val : r1_val;
		exec_next.operand_b = cpu_pkg::is_reg3(op) ? r3_val : imm;
		exec_next.store_data = r1_val;
	end

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			o_exec <= '{default: '0};
		else if (i_clear)
			o_exec <= '{default: '0};
		else if (i_advance)
			o_exec <= exec_next;
	end

	assign o_instr = o_exec.instr;

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module execute_stage (
	input  wire                       clock,
	input  wire                       reset,
	input  wire                       i_advance,
	input  wire                       i_clear,
	input  wire cpu_pkg::exec_req_t   i_exec,
	output cpu_pkg::word_t            o_result,
	output cpu_pkg::mem_req_t         o_mem,
	output logic                      o_flag_z,
	output logic                      o_flag_n
);

	cpu_pkg::opcode_t op;
	cpu_pkg::word_t alu;
	logic sets_flags;

	//////////////////////////////////////////////////
	// ALU

	always_comb
	begin
		op = cpu_pkg::op_of(i_exec.instr);
		case (op)
			// address, immediate add and branch target share the adder
			`CPU_OP_ADD, `CPU_OP_ADDI, `CPU_OP_LDIH,
			`CPU_OP_LOAD, `CPU_OP_STORE,
			`CPU_OP_BZ, `CPU_OP_BNZ, `CPU_OP_BN, `CPU_OP_BNN:
				alu = i_exec.operand_a + i_exec.operand_b;
			`CPU_OP_SUB, `CPU_OP_SUBI, `CPU_OP_CMP:
				alu = i_exec.operand_a - i_exec.operand_b;
			`CPU_OP_AND:
				alu = i_exec.operand_a & i_exec.operand_b;
			`CPU_OP_OR:
				alu = i_exec.operand_a | i_exec.operand_b;
			`CPU_OP_XOR:
				alu = i_exec.operand_a ^ i_exec.operand_b;
			// val8 comes through as operand b
			`CPU_OP_JUMP:
				alu = i_exec.operand_b;
			default:
				alu = '0;
		endcase
	end

	assign sets_flags = op inside {`CPU_OP_ADD, `CPU_OP_ADDI, `CPU_OP_LDIH,
		`CPU_OP_SUB, `CPU_OP_SUBI, `CPU_OP_CMP,
		`CPU_OP_AND, `CPU_OP_OR, `CPU_OP_XOR};

	assign o_result = alu;

	//////////////////////////////////////////////////
	// flags and execute-to-memory register

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			o_flag_z <= 1'b0;
			o_flag_n <= 1'b0;
			o_mem <= '{default: '0};
		end
		else if (i_clear)
		begin
			o_flag_z <= 1'b0;
			o_flag_n <= 1'b0;
			o_mem <= '{default: '0};
		end
		else if (i_advance)
		begin
			if (sets_flags)
			begin
				o_flag_z <= (alu == '0);
				o_flag_n <= alu[`CPU_WORD_W-1];
			end
			o_mem.instr <= i_exec.instr;
			o_mem.result <= alu;
			o_mem.store_data <= i_exec.store_data;
			o_mem.we <= (op == `CPU_OP_STORE);
		end
	end

endmodule

`default_nettype wire

// File: hw/writeback_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module writeback_stage (
	input  wire                       clock,
	input  wire                       reset,
	input  wire                       i_advance,
	input  wire                       i_clear,
	input  wire cpu_pkg::mem_req_t    i_mem,
	input  wire cpu_pkg::word_t       i_load_data,
	output cpu_pkg::word_t            o_mem_result,
	output cpu_pkg::reg_write_t       o_write,
	output logic                      o_halt
);

	cpu_pkg::word_t wb_instr;
	cpu_pkg::word_t wb_value;

	// memory stage result, also the forwarding source
	assign o_mem_result = (cpu_pkg::op_of(i_mem.instr) == `CPU_OP_LOAD) ? i_load_data : i_mem.result;

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			wb_instr <= cpu_pkg::nop_instr;
			wb_value <= '0;
		end
		else if (i_clear)
		begin
			wb_instr <= cpu_pkg::nop_instr;
			wb_value <= '0;
		end
		else if (i_advance)
		begin
			wb_instr <= i_mem.instr;
			wb_value <= o_mem_result;
		end
	end

	assign o_write.valid = cpu_pkg::writes_reg(cpu_pkg::op_of(wb_instr));
	assign o_write.index = cpu_pkg::r1_of(wb_instr);
	assign o_write.value = wb_value;
	assign o_halt = (cpu_pkg::op_of(wb_instr) == `CPU_OP_HALT);

endmodule

`default_nettype wire

// File: hw/data_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module data_mem (
	input  wire                       clock,
	input  wire                       i_running,
	input  wire                       i_advance,
	input  wire cpu_pkg::mem_req_t    i_mem,
	input  wire cpu_pkg::host_req_t   i_host,
	output cpu_pkg::word_t            o_load_data,
	output cpu_pkg::word_t            o_host_rdata
);

	cpu_pkg::word_t mem [`CPU_MEM_DEPTH];
	cpu_pkg::addr_t cpu_addr;

	// word address is the low byte of the ALU result
	assign cpu_addr = i_mem.result[`CPU_ADDR_W-1:0];

	always_ff @(posedge clock)
	begin
		if (i_running)
		begin
			if (i_advance && i_mem.we)
				mem[cpu_addr] <= i_mem.store_data;
		end
		else if (i_host.we && i_host.space)
			mem[i_host.addr] <= i_host.wdata;
	end

	assign o_load_data = mem[cpu_addr];
	assign o_host_rdata = mem[i_host.addr];

endmodule

`default_nettype wire

// File: hw/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
	input  wire                       clock,
	input  wire                       reset,
	input  wire                       i_start,
	input  wire                       i_enable,
	input  wire cpu_pkg::host_req_t   i_host,
	output wire                       o_running,
	output wire cpu_pkg::word_t       o_host_rdata
);

	logic advance;
	logic clear;
	logic wb_halt;
	logic flag_z;
	logic flag_n;

	cpu_pkg::host_req_t host_prog;
	cpu_pkg::word_t fetch_instr;
	cpu_pkg::word_t operand_instr;
	cpu_pkg::word_t execute_result;
	cpu_pkg::word_t mem_result;
	cpu_pkg::word_t load_data;
	cpu_pkg::exec_req_t exec_req;
	cpu_pkg::mem_req_t mem_req;
	cpu_pkg::reg_write_t reg_write;

	// program loads only land while idle
	always_comb
	begin
		host_prog = i_host;
		host_prog.we = i_host.we && !o_running;
	end

	run_control run_control_i (
		.clock     (clock),
		.reset     (reset),
		.i_start   (i_start),
		.i_enable  (i_enable),
		.i_wb_halt (wb_halt),
		.o_running (o_running),
		.o_advance (advance),
		.o_clear   (clear)
	);

	fetch_stage fetch_stage_i (
		.clock           (clock),
		.reset           (reset),
		.i_advance       (advance),
		.i_clear         (clear),
		.i_host          (host_prog),
		.i_operand_instr (operand_instr),
		.i_execute_instr (mem_req.instr),
		.i_mem           (mem_req),
		.i_flag_z        (flag_z),
		.i_flag_n        (flag_n),
		.o_instr         (fetch_instr)
	);

	operand_stage operand_stage_i (
		.clock            (clock),
		.reset            (reset),
		.i_advance        (advance),
		.i_clear          (clear),
		.i_instr          (fetch_instr),
		.i_execute_result (execute_result),
		.i_mem_result     (mem_result),
		.i_mem            (mem_req),
		.i_write          (reg_write),
		.o_exec           (exec_req),
		.o_instr          (operand_instr)
	);

	execute_stage execute_stage_i (
		.clock     (clock),
		.reset     (reset),
		.i_advance (advance),
		.i_clear   (clear),
		.i_exec    (exec_req),
		.o_result  (execute_result),
		.o_mem     (mem_req),
		.o_flag_z  (flag_z),
		.o_flag_n  (flag_n)
	);

	writeback_stage writeback_stage_i (
		.clock        (clock),
		.reset        (reset),
		.i_advance    (advance),
		.i_clear      (clear),
		.i_mem        (mem_req),
		.i_load_data  (load_data),
		.o_mem_result (mem_result),
		.o_write      (reg_write),
		.o_halt       (wb_halt)
	);

	data_mem data_mem_i (
		.clock        (clock),
		.i_running    (o_running),
		.i_advance    (advance),
		.i_mem        (mem_req),
		.i_host       (i_host),
		.o_load_data  (load_data),
		.o_host_rdata (o_host_rdata)
	);

endmodule

`default_nettype wire

// File: sim/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
	output logic o_clock,
	output logic o_reset
);

	// 20 ns period
	initial
	begin
		o_clock = 1'b0;
		forever
			#10 o_clock = ~o_clock;
	end

	// active low for the first eight rising edges
	initial
	begin
		o_reset = 1'b0;
		repeat (8)
			@(posedge o_clock);
		o_reset <= 1'b1;
	end

endmodule

`default_nettype wire

// File: sim/tb_cpu.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module tb_cpu;

	logic clock;
	logic reset;
	logic start;
	logic enable;
	logic running;
	cpu_pkg::host_req_t host;
	cpu_pkg::word_t host_rdata;

	cpu_pkg::word_t prog_img [`CPU_MEM_DEPTH];
	cpu_pkg::word_t model_mem [`CPU_MEM_DEPTH];
	cpu_pkg::word_t snap [`CPU_MEM_DEPTH];
	int prog_len;
	logic [31:0] lfsr_state = 32'h6a0a_31d1;

	clock_gen clock_gen_i (
		.o_clock (clock),
		.o_reset (reset)
	);

	cpu_top cpu_top_i (
		.clock        (clock),
		.reset        (reset),
		.i_start      (start),
		.i_enable     (enable),
		.i_host       (host),
		.o_running    (running),
		.o_host_rdata (host_rdata)
	);

	//////////////////////////////////////////////////
	// random numbers and failure handling

	// fibonacci taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic next_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < 8; i++)
			v = {v[6:0], next_bit()};
		return v;
	endfunction

	function automatic cpu_pkg::word_t random_word();
		cpu_pkg::word_t v;
		v[15:8] = random_byte();
		v[7:0] = random_byte();
		return v;
	endfunction

	function automatic void abort_run();
		$display("Test failures found");
		$fatal(1);
	endfunction

	task automatic check_value(input string name, input cpu_pkg::word_t expected,
		input cpu_pkg::word_t actual);
		if (actual !== expected)
		begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////
	// instruction encoding and program image

	function automatic cpu_pkg::word_t reg3_word(logic [4:0] op, logic [2:0] d,
		logic [2:0] a, logic [2:0] b);
		return {op, d, 1'b0, a, 1'b0, b};
	endfunction

	function automatic cpu_pkg::word_t imm_word(logic [4:0] op, logic [2:0] r, logic [7:0] v);
		return {op, r, v};
	endfunction

	// r1 is the data register, base + offset the address
	function automatic cpu_pkg::word_t mem_word(logic [4:0] op, logic [2:0] r,
		logic [2:0] base, logic [3:0] off);
		return {op, r, 1'b0, base, off};
	endfunction

	function automatic void clear_program();
		for (int a = 0; a < `CPU_MEM_DEPTH; a++)
			prog_img[a] = '0;
		prog_len = 0;
	endfunction

	function automatic void emit(cpu_pkg::word_t instr);
		prog_img[prog_len] = instr;
		prog_len++;
	endfunction

	// instruction-level model, runs prog_img against model_mem
	function automatic int run_reference();
		cpu_pkg::word_t regs [`CPU_REG_COUNT];
		cpu_pkg::word_t instr;
		cpu_pkg::word_t res;
		cpu_pkg::addr_t pc;
		cpu_pkg::addr_t ea;
		logic [4:0] op;
		logic [2:0] r1;
		logic [2:0] r2;
		logic [2:0] r3;
		logic [7:0] val8;
		logic [3:0] val4;
		logic flag_z;
		logic flag_n;
		logic sets;
		logic taken;
		logic halted;
		int steps;
		for (int i = 0; i < `CPU_REG_COUNT; i++)
			regs[i] = '0;
		pc = '0;
		flag_z = 1'b0;
		flag_n = 1'b0;
		halted = 1'b0;
		steps = 0;
		while (!halted && steps < 4000)
		begin
			steps++;
			instr = prog_img[pc];
			op = instr[15:11];
			r1 = instr[10:8];
			r2 = instr[6:4];
			r3 = instr[2:0];
			val8 = instr[7:0];
			val4 = instr[3:0];
			ea = regs[r2][7:0] + val4;
			res = '0;
			taken = 1'b0;
			case (op)
				`CPU_OP_HALT:            halted = 1'b1;
				`CPU_OP_LOAD:            regs[r1] = model_mem[ea];
				`CPU_OP_STORE:           model_mem[ea] = regs[r1];
				`CPU_OP_LDIH:            res = regs[r1] + {val8, 8'h00};
				`CPU_OP_ADD:             res = regs[r2] + regs[r3];
				`CPU_OP_ADDI:            res = regs[r1] + val8;
				`CPU_OP_SUB, `CPU_OP_CMP: res = regs[r2] - regs[r3];
				`CPU_OP_SUBI:            res = regs[r1] - val8;
				`CPU_OP_AND:             res = regs[r2] & regs[r3];
				`CPU_OP_OR:              res = regs[r2] | regs[r3];
				`CPU_OP_XOR:             res = regs[r2] ^ regs[r3];
				`CPU_OP_JUMP:            taken = 1'b1;
				`CPU_OP_BZ:              taken = flag_z;
				`CPU_OP_BNZ:             taken = !flag_z;
				`CPU_OP_BN:              taken = flag_n;
				`CPU_OP_BNN:             taken = !flag_n;
				default:                 res = '0;
			endcase
			sets = op inside {`CPU_OP_LDIH, `CPU_OP_ADD, `CPU_OP_ADDI, `CPU_OP_SUB,
				`CPU_OP_SUBI, `CPU_OP_CMP, `CPU_OP_AND, `CPU_OP_OR, `CPU_OP_XOR};
			if (sets)
			begin
				flag_z = (res == '0);
				flag_n = res[15];
				if (op != `CPU_OP_CMP)
					regs[r1] = res;
			end
			if (taken)
				pc = (op == `CPU_OP_JUMP) ? val8 : regs[r1][7:0] + val8;
			else
				pc = pc + 8'd1;
		end
		return halted ? steps : -1;
	endfunction

	//////////////////////////////////////////////////
	// host port and run control

	task automatic host_write(input logic sp, input cpu_pkg::addr_t a, input cpu_pkg::word_t d);
		@(posedge clock);
		host <= '{we: 1'b1, space: sp, addr: a, wdata: d};
	endtask

	task automatic host_release();
		@(posedge clock);
		host <= '{we: 1'b0, space: 1'b1, addr: '0, wdata: '0};
	endtask

	task automatic poke_data(input cpu_pkg::addr_t a, input cpu_pkg::word_t d);
		host_write(1'b1, a, d);
		model_mem[a] = d;
	endtask

	// rdata is combinational, sampled half a cycle later
	task automatic read_data(input cpu_pkg::addr_t a, output cpu_pkg::word_t v);
		@(posedge clock);
		host <= '{we: 1'b0, space: 1'b1, addr: a, wdata: '0};
		@(negedge clock);
		v = host_rdata;
	endtask

	task automatic compare_memory(input string name);
		cpu_pkg::word_t v;
		for (int a = 0; a < `CPU_MEM_DEPTH; a++)
		begin
			read_data(a[7:0], v);
			check_value($sformatf("%s mem[%0d]", name, a), model_mem[a], v);
		end
	endtask

	task automatic load_program();
		for (int a = 0; a < `CPU_MEM_DEPTH; a++)
			host_write(1'b0, a[7:0], prog_img[a]);
		host_release();
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (reset !== 1'b1 && n < 50)
		begin
			@(negedge clock);
			n++;
		end
		if (reset !== 1'b1)
		begin
			$display("reset was never released");
			abort_run();
		end
	endtask

	task automatic wait_running(input logic level, input int limit, input string name);
		int n;
		n = 0;
		while (running !== level && n < limit)
		begin
			@(negedge clock);
			n++;
		end
		if (running !== level)
		begin
			$display("timeout in %s: o_running did not become %0d", name, level);
			abort_run();
		end
	endtask

	task automatic pulse_start();
		@(posedge clock);
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
	endtask

	task automatic prepare_run(input string name);
		load_program();
		if (run_reference() < 0)
		begin
			$display("reference model never reached HALT in %s", name);
			abort_run();
		end
	endtask

	task automatic execute_test(input string name);
		prepare_run(name);
		pulse_start();
		wait_running(1'b1, 10, name);
		wait_running(1'b0, 4000, name);
		compare_memory(name);
	endtask

	//////////////////////////////////////////////////
	// test programs

	task automatic build_arith_program();
		logic [4:0] ops [5];
		ops = '{`CPU_OP_ADD, `CPU_OP_SUB, `CPU_OP_AND, `CPU_OP_OR, `CPU_OP_XOR};
		clear_program();
		emit(reg3_word(`CPU_OP_XOR, 0, 0, 0));
		emit(reg3_word(`CPU_OP_XOR, 7, 7, 7));
		emit(imm_word(`CPU_OP_ADDI, 7, 8'h40));
		emit(mem_word(`CPU_OP_LOAD, 1, 0, 0));
		emit(mem_word(`CPU_OP_LOAD, 2, 0, 1));
		for (int i = 0; i < 5; i++)
		begin
			emit(reg3_word(ops[i], 3, 1, 2));
			emit(mem_word(`CPU_OP_STORE, 3, 7, i));
		end
		emit(reg3_word(`CPU_OP_ADD, 4, 1, 0));
		emit(imm_word(`CPU_OP_ADDI, 4, random_byte()));
		emit(mem_word(`CPU_OP_STORE, 4, 7, 5));
		emit(reg3_word(`CPU_OP_ADD, 4, 2, 0));
		emit(imm_word(`CPU_OP_SUBI, 4, random_byte()));
		emit(mem_word(`CPU_OP_STORE, 4, 7, 6));
		emit(reg3_word(`CPU_OP_ADD, 4, 1, 0));
		emit(imm_word(`CPU_OP_LDIH, 4, random_byte()));
		emit(mem_word(`CPU_OP_STORE, 4, 7, 7));
		// CMP must leave its r1 field alone
		emit(reg3_word(`CPU_OP_ADD, 5, 0, 2));
		emit(reg3_word(`CPU_OP_CMP, 5, 1, 2));
		emit(mem_word(`CPU_OP_STORE, 5, 7, 8));
		emit(imm_word(`CPU_OP_HALT, 0, 0));
	endtask

	task automatic build_forward_program();
		clear_program();
		emit(reg3_word(`CPU_OP_XOR, 0, 0, 0));
		emit(reg3_word(`CPU_OP_XOR, 7, 7, 7));
		emit(imm_word(`CPU_OP_ADDI, 7, 8'h50));
		emit(mem_word(`CPU_OP_LOAD, 1, 0, 2));
		emit(mem_word(`CPU_OP_LOAD, 2, 0, 3));
		emit(reg3_word(`CPU_OP_ADD, 3, 1, 2));
		emit(reg3_word(`CPU_OP_ADD, 4, 3, 1));
		emit(reg3_word(`CPU_OP_SUB, 5, 1, 3));
		emit(reg3_word(`CPU_OP_XOR, 6, 3, 4));
		emit(mem_word(`CPU_OP_STORE, 6, 7, 0));
		emit(imm_word(`CPU_OP_ADDI, 5, random_byte()));
		emit(mem_word(`CPU_OP_STORE, 5, 7, 1));
		emit(mem_word(`CPU_OP_STORE, 4, 7, 2));
		emit(reg3_word(`CPU_OP_OR, 3, 5, 6));
		emit(mem_word(`CPU_OP_STORE, 3, 7, 3));
		// distances two and three
		emit(reg3_word(`CPU_OP_ADD, 1, 1, 2));
		emit(imm_word(`CPU_OP_NOP, 0, 0));
		emit(mem_word(`CPU_OP_STORE, 1, 7, 4));
		emit(reg3_word(`CPU_OP_ADD, 2, 2, 2));
		emit(imm_word(`CPU_OP_NOP, 0, 0));
		emit(imm_word(`CPU_OP_NOP, 0, 0));
		emit(mem_word(`CPU_OP_STORE, 2, 7, 5));
		// forwarded base register
		emit(imm_word(`CPU_OP_SUBI, 7, 8'h01));
		emit(mem_word(`CPU_OP_STORE, 3, 7, 0));
		emit(imm_word(`CPU_OP_HALT, 0, 0));
	endtask

	task automatic build_load_use_program();
		clear_program();
		emit(reg3_word(`CPU_OP_XOR, 0, 0, 0));
		emit(reg3_word(`CPU_OP_XOR, 7, 7, 7));
		emit(imm_word(`CPU_OP_ADDI, 7, 8'h60));
		emit(mem_word(`CPU_OP_LOAD, 1, 0, 4));
		emit(mem_word(`CPU_OP_STORE, 1, 7, 0));
		emit(mem_word(`CPU_OP_LOAD, 2, 0, 5));
		emit(reg3_word(`CPU_OP_ADD, 3, 2, 1));
		emit(mem_word(`CPU_OP_STORE, 3, 7, 1));
		emit(mem_word(`CPU_OP_LOAD, 4, 0, 6));
		emit(imm_word(`CPU_OP_NOP, 0, 0));
		emit(reg3_word(`CPU_OP_SUB, 5, 4, 2));
		emit(mem_word(`CPU_OP_STORE, 5, 7, 2));
		emit(mem_word(`CPU_OP_LOAD, 5, 7, 0));
		emit(imm_word(`CPU_OP_ADDI, 5, random_byte()));
		emit(mem_word(`CPU_OP_STORE, 5, 7, 3));
		// loaded value used as an address
		emit(mem_word(`CPU_OP_LOAD, 1, 0, 9));
		emit(mem_word(`CPU_OP_LOAD, 6, 1, 3));
		emit(mem_word(`CPU_OP_STORE, 6, 7, 4));
		emit(mem_word(`CPU_OP_LOAD, 7, 0, 10));
		emit(mem_word(`CPU_OP_STORE, 7, 7, 5));
		emit(imm_word(`CPU_OP_HALT, 0, 0));
	endtask

	// countdown from count, markers per iteration around r4 = 0x70 + i
	task automatic build_loop_program(input logic [7:0] count, input logic [7:0] thresh);
		clear_program();
		emit(reg3_word(`CPU_OP_XOR, 0, 0, 0));
		emit(reg3_word(`CPU_OP_XOR, 7, 7, 7));
		emit(imm_word(`CPU_OP_ADDI, 7, 8'h70));
		emit(reg3_word(`CPU_OP_XOR, 1, 1, 1));
		emit(imm_word(`CPU_OP_ADDI, 1, count));
		emit(reg3_word(`CPU_OP_XOR, 2, 2, 2));
		emit(reg3_word(`CPU_OP_XOR, 3, 3, 3));
		emit(imm_word(`CPU_OP_ADDI, 3, thresh));
		// loop head at 8
		emit(imm_word(`CPU_OP_ADDI, 2, 8'h01));
		emit(reg3_word(`CPU_OP_ADD, 4, 7, 2));
		emit(reg3_word(`CPU_OP_CMP, 0, 1, 3));
		emit(imm_word(`CPU_OP_BN, 0, 8'd14));
		emit(mem_word(`CPU_OP_STORE, 1, 4, 0));
		emit(imm_word(`CPU_OP_JUMP, 0, 8'd15));
		emit(mem_word(`CPU_OP_STORE, 2, 4, 8));
		emit(reg3_word(`CPU_OP_CMP, 0, 1, 3));
		emit(imm_word(`CPU_OP_BNN, 0, 8'd18));
		emit(mem_word(`CPU_OP_STORE, 3, 4, 4));
		emit(imm_word(`CPU_OP_SUBI, 1, 8'h01));
		emit(imm_word(`CPU_OP_BNZ, 0, 8'd8));
		emit(imm_word(`CPU_OP_BZ, 0, 8'd22));
		emit(mem_word(`CPU_OP_STORE, 7, 0, 15));
		emit(mem_word(`CPU_OP_STORE, 2, 7, 15));
		emit(imm_word(`CPU_OP_HALT, 0, 0));
	endtask

	task automatic pause_test();
		cpu_pkg::word_t v;
		build_loop_program(8'd6, 8'd3);
		prepare_run("enable pause");
		pulse_start();
		wait_running(1'b1, 10, "enable pause");
		repeat (12)
			@(posedge clock);
		enable <= 1'b0;
		for (int a = 0; a < `CPU_MEM_DEPTH; a++)
			read_data(a[7:0], snap[a]);
		@(negedge clock);
		check_value("enable pause running", 16'h0001, {15'h0, running});
		for (int a = 0; a < `CPU_MEM_DEPTH; a++)
		begin
			read_data(a[7:0], v);
			check_value($sformatf("enable pause hold mem[%0d]", a), snap[a], v);
		end
		@(posedge clock);
		enable <= 1'b1;
		wait_running(1'b0, 4000, "enable pause");
		compare_memory("enable pause");
	endtask

	//////////////////////////////////////////////////
	// test sequence

	initial
	begin
		logic [7:0] count;
		start = 1'b0;
		enable = 1'b1;
		host = '0;
		wait_reset();

		@(negedge clock);
		check_value("idle after reset", 16'h0000, {15'h0, running});
		for (int a = 0; a < `CPU_MEM_DEPTH; a++)
			poke_data(a[7:0], random_word() ^ {a[7:0], ~a[7:0]});
		host_release();
		compare_memory("host readback");

		for (int round = 0; round < 3; round++)
		begin
			poke_data(8'd0, random_word());
			poke_data(8'd1, random_word());
			host_release();
			build_arith_program();
			execute_test($sformatf("arith round %0d", round));
		end

		build_forward_program();
		execute_test("forwarding");
		build_load_use_program();
		execute_test("load-use");

		build_loop_program(8'd5, 8'd3);
		execute_test("branch loop");
		count = 8'd2 + (random_byte() % 8'd5);
		build_loop_program(count, 8'd1 + (random_byte() % count));
		execute_test("branch loop random");

		pause_test();

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hw
hw/cpu_pkg.sv
hw/run_control.sv
hw/fetch_stage.sv
hw/operand_stage.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/data_mem.sv
hw/cpu_top.sv
sim/clock_gen.sv
sim/tb_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_cpu -f tb.f

# tee keeps the pipeline status zero so the log search decides
./obj_dir/Vtb_cpu | tee sim.log

if grep -q 'All tests passed!' sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
